/* design/conditionUnit.sv */
// Status register and branch conditions
module conditionUnit (
	input  logic                                  Clock,
	input  logic                                  nReset,
	input  logic [cpuControlPkg::FlagWidth-1:0]   flags,
	input  logic                                  statusWe,
	input  cpuControlPkg::branchCond_t            cond,
	output logic [cpuControlPkg::FlagWidth-1:0]   statusReg,
	output logic                                  cFlag,
	output logic                                  branchTaken
);

	logic zFlag;
	logic nFlag;
	logic vFlag;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			statusReg <= '0;
		else if (statusWe)
			statusReg <= flags;
	end

	assign zFlag = statusReg[cpuControlPkg::FlagZ];
	assign nFlag = statusReg[cpuControlPkg::FlagN];
	assign vFlag = statusReg[cpuControlPkg::FlagV];
	assign cFlag = statusReg[cpuControlPkg::FlagC];

	always_comb begin
		case (cond)
			cpuControlPkg::BR,
			cpuControlPkg::BWL:
				branchTaken = 1'b1;
			cpuControlPkg::BNE:
				branchTaken = ~zFlag;
			cpuControlPkg::BE:
				branchTaken = zFlag;
			// Signed compare result
			cpuControlPkg::BLT:
				branchTaken = nFlag ^ vFlag;
			cpuControlPkg::BGE:
				branchTaken = ~(nFlag ^ vFlag);
			// RET and JMP choose their own PC source
			default:
				branchTaken = 1'b0;
		endcase
	end

endmodule

/* design/controlDecode.sv */
// Bus and datapath control decoder
module controlDecode (
	input  cpuControlPkg::major_t    major,
	input  cpuControlPkg::subCycle_t sub,
	input  cpuControlPkg::instr_t    instr,
	input  logic                     branchTaken,
	input  logic                     nWait,
	output cpuControlPkg::busCtrl_t  bus,
	output cpuControlPkg::pathCtrl_t path,
	output logic                     statusWe,
	output logic                     intEnable,
	output logic                     intDisable
);

	logic isStore;
	logic aluOp;

	assign isStore = instr.opcode == cpuControlPkg::STW;
	// Everything from ADD up to ASR updates the flags
	assign aluOp = instr.opcode <= cpuControlPkg::ASR;

	always_comb begin
		bus = '{ale: 1'b0, nMe: 1'b1, nOe: 1'b1, nWe: 1'b1, memEn: 1'b0, enb: 1'b0};
		path = '{
			aluEn: 1'b0,
			aluWe: 1'b0,
			aluOr: cpuControlPkg::AluOrNone,
			op1Sel: cpuControlPkg::Op1Rd1,
			op2Sel: cpuControlPkg::Op2Imm,
			immSel: cpuControlPkg::ImmLong,
			rs1Sel: cpuControlPkg::Rs1Ra,
			rwSel: cpuControlPkg::RwRd,
			wdSel: cpuControlPkg::WdAlu,
			regWe: 1'b0,
			irWe: 1'b0,
			pcEn: 1'b0,
			pcWe: 1'b0,
			pcSel: cpuControlPkg::PcInc,
			lrEn: 1'b0,
			lrWe: 1'b0,
			lrSel: cpuControlPkg::LrSys
		};
		statusWe = 1'b0;
		intEnable = 1'b0;
		intDisable = 1'b0;

		case ({major, sub})
			// Instruction fetch, PC drives the address
			{cpuControlPkg::Fetch, cpuControlPkg::Cycle0}: begin
				bus.ale = 1'b1;
				path.pcEn = 1'b1;
			end
			{cpuControlPkg::Fetch, cpuControlPkg::Cycle1}: begin
				bus.nMe = 1'b0;
				bus.memEn = 1'b1;
				path.pcEn = 1'b1;
			end
			{cpuControlPkg::Fetch, cpuControlPkg::Cycle2}: begin
				bus.nMe = 1'b0;
				bus.nOe = 1'b0;
				bus.memEn = 1'b1;
				bus.enb = 1'b1;
				path.irWe = nWait;
			end
			{cpuControlPkg::Fetch, cpuControlPkg::Cycle3}:
				path.pcEn = 1'b1;

			{cpuControlPkg::Execute, cpuControlPkg::Cycle4}: begin
				if (aluOp) begin
					path.pcEn = 1'b1;
					path.pcWe = 1'b1;
					statusWe = 1'b1;
					// Compare only sets the flags
					path.regWe = !(instr.opcode inside {cpuControlPkg::CMP, cpuControlPkg::CMPI});
					if (instr.opcode inside {cpuControlPkg::ADD, cpuControlPkg::ADC,
							cpuControlPkg::SUB, cpuControlPkg::SUC, cpuControlPkg::CMP,
							cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
							cpuControlPkg::NAND, cpuControlPkg::NOR})
						path.op2Sel = cpuControlPkg::Op2Rd2;
					if (instr.opcode inside {cpuControlPkg::ADDI, cpuControlPkg::ADCI,
							cpuControlPkg::SUBI, cpuControlPkg::SUCI, cpuControlPkg::CMPI,
							cpuControlPkg::LSL, cpuControlPkg::LSR, cpuControlPkg::ASR})
						path.immSel = cpuControlPkg::ImmShort;
					// Byte immediates act on rd in place
					if (instr.opcode inside {cpuControlPkg::ADDIB, cpuControlPkg::SUBIB})
						path.rs1Sel = cpuControlPkg::Rs1Rd;
				end else begin
					case (instr.opcode)
						cpuControlPkg::LUI,
						cpuControlPkg::LLI: begin
							path.aluEn = 1'b1;
							path.rs1Sel = cpuControlPkg::Rs1Rd;
							path.regWe = 1'b1;
							path.pcWe = 1'b1;
						end
						// Effective address rd + offset into the ALU register
						cpuControlPkg::LDW,
						cpuControlPkg::STW: begin
							path.aluEn = 1'b1;
							path.aluWe = 1'b1;
							path.immSel = cpuControlPkg::ImmShort;
						end
						cpuControlPkg::BRANCH: begin
							path.pcWe = 1'b1;
							case (instr.cond.branch)
								cpuControlPkg::RET: begin
									path.lrEn = 1'b1;
									path.pcSel = cpuControlPkg::PcSysbus;
								end
								cpuControlPkg::JMP: begin
									path.immSel = cpuControlPkg::ImmShort;
									path.pcSel = cpuControlPkg::PcAluOut;
								end
								default: begin
									// PC relative with the long offset
									path.aluEn = 1'b1;
									path.op1Sel = cpuControlPkg::Op1Pc;
									if (branchTaken) begin
										path.pcSel = cpuControlPkg::PcAluOut;
										if (instr.cond.branch == cpuControlPkg::BWL) begin
											path.lrWe = 1'b1;
											path.lrSel = cpuControlPkg::LrPc;
										end
									end
								end
							endcase
						end
						cpuControlPkg::INTCTRL: begin
							path.pcEn = 1'b1;
							path.pcWe = 1'b1;
							intEnable = instr.cond.intCtrl == cpuControlPkg::IntOn;
							intDisable = instr.cond.intCtrl == cpuControlPkg::IntOff;
						end
						// Undefined codes step over
						default: begin
							path.pcEn = 1'b1;
							path.pcWe = 1'b1;
						end
					endcase
				end
			end

			// Data transfer of LDW and STW
			{cpuControlPkg::Execute, cpuControlPkg::Cycle0}: begin
				bus.ale = 1'b1;
				path.aluEn = 1'b1;
				path.immSel = cpuControlPkg::ImmShort;
			end
			{cpuControlPkg::Execute, cpuControlPkg::Cycle1}: begin
				bus.nMe = 1'b0;
				bus.memEn = !isStore;
				path.aluEn = 1'b1;
				path.aluWe = 1'b1;
				path.op2Sel = cpuControlPkg::Op2Zero;
				path.rs1Sel = cpuControlPkg::Rs1Rd;
			end
			{cpuControlPkg::Execute, cpuControlPkg::Cycle2}: begin
				bus.nMe = 1'b0;
				path.pcWe = nWait;
				if (isStore) begin
					bus.nWe = 1'b0;
					path.aluEn = 1'b1;
					path.op2Sel = cpuControlPkg::Op2Zero;
				end else begin
					bus.nOe = 1'b0;
					bus.memEn = 1'b1;
					bus.enb = 1'b1;
					path.wdSel = cpuControlPkg::WdSys;
					path.regWe = 1'b1;
				end
			end
			{cpuControlPkg::Execute, cpuControlPkg::Cycle3}: begin
				if (isStore) begin
					bus.nWe = 1'b0;
					path.aluEn = 1'b1;
					path.op2Sel = cpuControlPkg::Op2Zero;
				end else begin
					path.pcEn = 1'b1;
				end
			end

			// Interrupt entry pushes the PC below register seven
			{cpuControlPkg::Interrupt, cpuControlPkg::Cycle4}: begin
				intDisable = 1'b1;
				path.aluEn = 1'b1;
				path.aluWe = 1'b1;
				path.aluOr = cpuControlPkg::AluOrSub;
				path.op2Sel = cpuControlPkg::Op2Zero;
				path.rs1Sel = cpuControlPkg::Rs1Seven;
				path.rwSel = cpuControlPkg::RwSeven;
				path.regWe = 1'b1;
			end
			{cpuControlPkg::Interrupt, cpuControlPkg::Cycle0}: begin
				bus.ale = 1'b1;
				path.aluEn = 1'b1;
				path.aluOr = cpuControlPkg::AluOrSub;
				path.op2Sel = cpuControlPkg::Op2Zero;
				path.rs1Sel = cpuControlPkg::Rs1Seven;
			end
			{cpuControlPkg::Interrupt, cpuControlPkg::Cycle1}: begin
				bus.nMe = 1'b0;
				path.aluEn = 1'b1;
				path.op2Sel = cpuControlPkg::Op2Zero;
			end
			{cpuControlPkg::Interrupt, cpuControlPkg::Cycle2}: begin
				bus.nMe = 1'b0;
				bus.nWe = 1'b0;
				path.pcEn = 1'b1;
			end
			{cpuControlPkg::Interrupt, cpuControlPkg::Cycle3}: begin
				bus.nWe = 1'b0;
				path.pcEn = 1'b1;
				path.pcWe = 1'b1;
				path.pcSel = cpuControlPkg::PcInt;
			end
			default: ;
		endcase
	end

endmodule

/* design/cpuControl.sv */
// Processor control unit
module cpuControl (
	input  logic                                  Clock,
	input  logic                                  nReset,
	input  cpuControlPkg::instr_t                 instr,
	input  logic [cpuControlPkg::FlagWidth-1:0]   flags,
	input  logic                                  nWait,
	input  logic                                  nIrq,
	output cpuControlPkg::busCtrl_t               bus,
	output cpuControlPkg::pathCtrl_t              path,
	output logic [cpuControlPkg::FlagWidth-1:0]   statusReg,
	output logic                                  cFlag
);

	cpuControlPkg::major_t    major;
	cpuControlPkg::subCycle_t sub;
	logic                     intReq;
	logic                     intEnable;
	logic                     intDisable;
	logic                     statusWe;
	logic                     branchTaken;

	irqSync irqSync (
		.Clock      (Clock),
		.nReset     (nReset),
		.nIrq       (nIrq),
		.intEnable  (intEnable),
		.intDisable (intDisable),
		.intReq     (intReq)
	);

	conditionUnit conditionUnit (
		.Clock       (Clock),
		.nReset      (nReset),
		.flags       (flags),
		.statusWe    (statusWe),
		.cond        (instr.cond.branch),
		.statusReg   (statusReg),
		.cFlag       (cFlag),
		.branchTaken (branchTaken)
	);

	sequencer sequencer (
		.Clock  (Clock),
		.nReset (nReset),
		.instr  (instr),
		.nWait  (nWait),
		.intReq (intReq),
		.major  (major),
		.sub    (sub)
	);

	controlDecode controlDecode (
		.major       (major),
		.sub         (sub),
		.instr       (instr),
		.branchTaken (branchTaken),
		.nWait       (nWait),
		.bus         (bus),
		.path        (path),
		.statusWe    (statusWe),
		.intEnable   (intEnable),
		.intDisable  (intDisable)
	);

endmodule

/* design/cpuControlPkg.sv */
// CPU control definitions
package cpuControlPkg;

	localparam int FlagWidth = 4;

	// Bit positions in the status register
	localparam int FlagZ = 0;
	localparam int FlagC = 1;
	localparam int FlagV = 2;
	localparam int FlagN = 3;

	// Major opcode, top five bits of the instruction byte
	typedef enum logic [4:0] {
		ADD     = 5'd0,
		ADDI    = 5'd1,
		ADDIB   = 5'd2,
		ADC     = 5'd3,
		ADCI    = 5'd4,
		SUB     = 5'd5,
		SUBI    = 5'd6,
		SUBIB   = 5'd7,
		SUC     = 5'd8,
		SUCI    = 5'd9,
		NEG     = 5'd10,
		CMP     = 5'd11,
		CMPI    = 5'd12,
		AND     = 5'd13,
		OR      = 5'd14,
		XOR     = 5'd15,
		NOT     = 5'd16,
		NAND    = 5'd17,
		NOR     = 5'd18,
		LSL     = 5'd19,
		LSR     = 5'd20,
		ASR     = 5'd21,
		LUI     = 5'd22,
		LLI     = 5'd23,
		BRANCH  = 5'd24,
		LDW     = 5'd25,
		STW     = 5'd26,
		INTCTRL = 5'd27
	} opcode_t;

	typedef enum logic [2:0] {
		BR  = 3'd0,
		BNE = 3'd1,
		BE  = 3'd2,
		BLT = 3'd3,
		BGE = 3'd4,
		BWL = 3'd5,
		RET = 3'd6,
		JMP = 3'd7
	} branchCond_t;

	// Subfunction of INTCTRL
	typedef enum logic [2:0] {
		IntOn  = 3'd1,
		IntOff = 3'd2
	} intCtrl_t;

	// Low three bits read as condition for BRANCH, subfunction for INTCTRL
	typedef union packed {
		branchCond_t branch;
		intCtrl_t    intCtrl;
	} condField_u;

	typedef struct packed {
		opcode_t    opcode;
		condField_u cond;
	} instr_t;

	typedef enum logic [1:0] {Fetch, Execute, Interrupt} major_t;
	typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycle_t;

	// Zero is the idle choice of every select
	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Sel_t;
	typedef enum logic {ImmLong, ImmShort} immSel_t;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Seven} rs1Sel_t;
	typedef enum logic {RwRd, RwSeven} rwSel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;
	typedef enum logic [1:0] {PcInc, PcAluOut, PcSysbus, PcInt} pcSel_t;
	typedef enum logic [1:0] {AluOrNone, AluOrAdd, AluOrSub} aluOr_t;
	typedef enum logic {LrSys, LrPc} lrSel_t;

	// Strobes of the external asynchronous bus
	typedef struct packed {
		logic ale;
		logic nMe;
		logic nOe;
		logic nWe;
		logic memEn;
		logic enb;
	} busCtrl_t;

	typedef struct packed {
		logic    aluEn;
		logic    aluWe;
		aluOr_t  aluOr;
		op1Sel_t op1Sel;
		op2Sel_t op2Sel;
		immSel_t immSel;
		rs1Sel_t rs1Sel;
		rwSel_t  rwSel;
		wdSel_t  wdSel;
		logic    regWe;
		logic    irWe;
		logic    pcEn;
		logic    pcWe;
		pcSel_t  pcSel;
		logic    lrEn;
		logic    lrWe;
		lrSel_t  lrSel;
	} pathCtrl_t;

endpackage

/* design/irqSync.sv */
// Interrupt request synchroniser
module irqSync (
	input  logic Clock,
	input  logic nReset,
	input  logic nIrq,
	input  logic intEnable,
	input  logic intDisable,
	output logic intReq
);

	logic irqFirst;
	logic irqSecond;
	logic enabled;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqFirst <= 1'b0;
			irqSecond <= 1'b0;
			enabled <= 1'b0;
		end else begin
			// Pin is active low and asynchronous
			irqFirst <= ~nIrq;
			irqSecond <= irqFirst;
			// Disable wins if both arrive together
			if (intDisable)
				enabled <= 1'b0;
			else if (intEnable)
				enabled <= 1'b1;
		end
	end

	assign intReq = irqSecond & enabled;

endmodule

/* design/sequencer.sv */
// Major state and sub-cycle sequencer
module sequencer (
	input  logic                     Clock,
	input  logic                     nReset,
	input  cpuControlPkg::instr_t    instr,
	input  logic                     nWait,
	input  logic                     intReq,
	output cpuControlPkg::major_t    major,
	output cpuControlPkg::subCycle_t sub
);

	cpuControlPkg::major_t    majorNext;
	cpuControlPkg::subCycle_t subNext;
	cpuControlPkg::major_t    endMajor;
	cpuControlPkg::subCycle_t endSub;
	logic                     memOp;
	logic                     flowOp;

	assign memOp = instr.opcode inside {cpuControlPkg::LDW, cpuControlPkg::STW};
	assign flowOp = instr.opcode inside {cpuControlPkg::BRANCH, cpuControlPkg::INTCTRL};

	// Where an instruction goes when it ends
	assign endMajor = intReq ? cpuControlPkg::Interrupt : cpuControlPkg::Fetch;
	assign endSub = intReq ? cpuControlPkg::Cycle4 : cpuControlPkg::Cycle0;

	always_comb begin
		majorNext = major;
		subNext = sub;
		case (sub)
			cpuControlPkg::Cycle0:
				subNext = cpuControlPkg::Cycle1;
			cpuControlPkg::Cycle1:
				subNext = cpuControlPkg::Cycle2;
			cpuControlPkg::Cycle2: begin
				// Memory cycles stretch on nWait but interrupt entry never does
				if (nWait || major == cpuControlPkg::Interrupt)
					subNext = cpuControlPkg::Cycle3;
			end
			cpuControlPkg::Cycle3: begin
				case (major)
					cpuControlPkg::Fetch: begin
						majorNext = cpuControlPkg::Execute;
						subNext = cpuControlPkg::Cycle4;
					end
					cpuControlPkg::Execute: begin
						majorNext = endMajor;
						subNext = endSub;
					end
					default: begin
						majorNext = cpuControlPkg::Fetch;
						subNext = cpuControlPkg::Cycle0;
					end
				endcase
			end
			cpuControlPkg::Cycle4: begin
				if (major == cpuControlPkg::Execute && !memOp) begin
					majorNext = flowOp ? cpuControlPkg::Fetch : endMajor;
					subNext = flowOp ? cpuControlPkg::Cycle0 : endSub;
				end else begin
					subNext = cpuControlPkg::Cycle0;
				end
			end
			default: begin
				majorNext = cpuControlPkg::Fetch;
				subNext = cpuControlPkg::Cycle0;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			major <= cpuControlPkg::Fetch;
			sub <= cpuControlPkg::Cycle0;
		end else begin
			major <= majorNext;
			sub <= subNext;
		end
	end

endmodule

/* list.f */
+incdir+sim
design/cpuControlPkg.sv
design/irqSync.sv
design/conditionUnit.sv
design/sequencer.sv
design/controlDecode.sv
design/cpuControl.sv
sim/tbClock.sv
sim/cpuControlTb.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps -f list.f --top-module cpuControlTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if grep -q "Test completed successfully" sim.log; then
	exit 0
fi
echo "Simulation ended without a result"
exit 1

/* sim/controlModel.svh */
// Cycle-level control unit model
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

	cpuControlPkg::major_t               modelMajor;
	cpuControlPkg::subCycle_t            modelSub;
	logic [cpuControlPkg::FlagWidth-1:0] modelStatus;
	logic                                irqFirst;
	logic                                irqSecond;
	logic                                intOn;
	int                                  instrDone;
	int                                  entries;

	// Expected outputs of the current cycle
	logic                                expAle;
	logic                                expNMe;
	logic                                expNOe;
	logic                                expNWe;
	logic                                expIrWe;
	logic                                expRegWe;
	logic                                expPcWe;
	logic                                expLrEn;
	logic                                expLrWe;
	logic                                expStatusWe;
	logic                                expIntEnable;
	logic                                expIntDisable;
	cpuControlPkg::wdSel_t               expWdSel;
	cpuControlPkg::pcSel_t               expPcSel;

	task automatic resetModel();
		modelMajor = cpuControlPkg::Fetch;
		modelSub = cpuControlPkg::Cycle0;
		modelStatus = '0;
		irqFirst = 1'b0;
		irqSecond = 1'b0;
		intOn = 1'b0;
	endtask

	function automatic logic conditionHolds(input cpuControlPkg::branchCond_t cond,
			input logic [cpuControlPkg::FlagWidth-1:0] status);
		logic z;
		logic n;
		logic v;
		z = status[cpuControlPkg::FlagZ];
		n = status[cpuControlPkg::FlagN];
		v = status[cpuControlPkg::FlagV];
		case (cond)
			cpuControlPkg::BR,
			cpuControlPkg::BWL:
				return 1'b1;
			cpuControlPkg::BNE:
				return !z;
			cpuControlPkg::BE:
				return z;
			cpuControlPkg::BLT:
				return n != v;
			cpuControlPkg::BGE:
				return n == v;
			default:
				return 1'b0;
		endcase
	endfunction

	task automatic predictOutputs(input cpuControlPkg::instr_t ins, input logic waitHigh);
		logic fetch;
		logic intr;
		logic exec4;
		logic load;
		logic store;
		logic alu;
		fetch = modelMajor == cpuControlPkg::Fetch;
		intr = modelMajor == cpuControlPkg::Interrupt;
		exec4 = modelMajor == cpuControlPkg::Execute && modelSub == cpuControlPkg::Cycle4;
		load = modelMajor == cpuControlPkg::Execute && ins.opcode == cpuControlPkg::LDW;
		store = modelMajor == cpuControlPkg::Execute && ins.opcode == cpuControlPkg::STW;
		alu = ins.opcode <= cpuControlPkg::ASR;

		// Every bus cycle: address, two strobe cycles, then release
		expAle = modelSub == cpuControlPkg::Cycle0;
		expNMe = !(modelSub inside {cpuControlPkg::Cycle1, cpuControlPkg::Cycle2});
		expNOe = !(modelSub == cpuControlPkg::Cycle2 && (fetch || load));
		expNWe = !(modelSub inside {cpuControlPkg::Cycle2, cpuControlPkg::Cycle3}
			&& (intr || store));
		expIrWe = fetch && modelSub == cpuControlPkg::Cycle2 && waitHigh;

		expRegWe = (exec4 && alu && !(ins.opcode inside {cpuControlPkg::CMP, cpuControlPkg::CMPI}))
			|| (exec4 && ins.opcode inside {cpuControlPkg::LUI, cpuControlPkg::LLI})
			|| (load && modelSub == cpuControlPkg::Cycle2)
			|| (intr && modelSub == cpuControlPkg::Cycle4);
		expWdSel = (load && modelSub == cpuControlPkg::Cycle2) ?
			cpuControlPkg::WdSys : cpuControlPkg::WdAlu;
		expPcWe = (exec4 && !(load || store))
			|| ((load || store) && modelSub == cpuControlPkg::Cycle2 && waitHigh)
			|| (intr && modelSub == cpuControlPkg::Cycle3);

		expPcSel = cpuControlPkg::PcInc;
		expLrEn = 1'b0;
		expLrWe = 1'b0;
		if (intr && modelSub == cpuControlPkg::Cycle3)
			expPcSel = cpuControlPkg::PcInt;
		if (exec4 && ins.opcode == cpuControlPkg::BRANCH) begin
			case (ins.cond.branch)
				cpuControlPkg::RET: begin
					expPcSel = cpuControlPkg::PcSysbus;
					expLrEn = 1'b1;
				end
				cpuControlPkg::JMP:
					expPcSel = cpuControlPkg::PcAluOut;
				default: begin
					if (conditionHolds(ins.cond.branch, modelStatus))
						expPcSel = cpuControlPkg::PcAluOut;
					expLrWe = ins.cond.branch == cpuControlPkg::BWL;
				end
			endcase
		end

		expStatusWe = exec4 && alu;
		expIntEnable = exec4 && ins.opcode == cpuControlPkg::INTCTRL
			&& ins.cond.intCtrl == cpuControlPkg::IntOn;
		expIntDisable = (exec4 && ins.opcode == cpuControlPkg::INTCTRL
			&& ins.cond.intCtrl == cpuControlPkg::IntOff)
			|| (intr && modelSub == cpuControlPkg::Cycle4);
	endtask

	task automatic endInstruction(input logic enter);
		instrDone = instrDone + 1;
		if (enter) begin
			modelMajor = cpuControlPkg::Interrupt;
			modelSub = cpuControlPkg::Cycle4;
			entries = entries + 1;
		end else begin
			modelMajor = cpuControlPkg::Fetch;
			modelSub = cpuControlPkg::Cycle0;
		end
	endtask

	// One rising edge, using the inputs held through the cycle
	task automatic advanceModel(input cpuControlPkg::instr_t ins, input logic waitHigh,
			input logic irqPin, input logic [cpuControlPkg::FlagWidth-1:0] flagsIn);
		logic intReq;
		logic memOp;
		logic flowOp;
		logic stepOn;
		intReq = irqSecond && intOn;
		memOp = ins.opcode inside {cpuControlPkg::LDW, cpuControlPkg::STW};
		flowOp = ins.opcode inside {cpuControlPkg::BRANCH, cpuControlPkg::INTCTRL};
		stepOn = modelSub != cpuControlPkg::Cycle2 || waitHigh;

		case (modelMajor)
			cpuControlPkg::Fetch: begin
				if (modelSub == cpuControlPkg::Cycle3) begin
					modelMajor = cpuControlPkg::Execute;
					modelSub = cpuControlPkg::Cycle4;
				end else if (stepOn) begin
					modelSub = cpuControlPkg::subCycle_t'(modelSub + 3'd1);
				end
			end
			cpuControlPkg::Execute: begin
				if ((modelSub == cpuControlPkg::Cycle4 && !memOp)
						|| modelSub == cpuControlPkg::Cycle3)
					endInstruction(intReq && !flowOp);
				else if (modelSub == cpuControlPkg::Cycle4)
					modelSub = cpuControlPkg::Cycle0;
				else if (stepOn)
					modelSub = cpuControlPkg::subCycle_t'(modelSub + 3'd1);
			end
			default: begin
				// Interrupt entry ignores nWait
				if (modelSub == cpuControlPkg::Cycle4) begin
					modelSub = cpuControlPkg::Cycle0;
				end else if (modelSub == cpuControlPkg::Cycle3) begin
					modelMajor = cpuControlPkg::Fetch;
					modelSub = cpuControlPkg::Cycle0;
				end else begin
					modelSub = cpuControlPkg::subCycle_t'(modelSub + 3'd1);
				end
			end
		endcase

		if (expStatusWe)
			modelStatus = flagsIn;
		if (expIntDisable)
			intOn = 1'b0;
		else if (expIntEnable)
			intOn = 1'b1;
		irqSecond = irqFirst;
		irqFirst = !irqPin;
	endtask

`endif

/* sim/cpuControlTb.sv */
// Control unit testbench
module cpuControlTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int InstrCount = 3000;
	localparam int CycleLimit = 100000;
	localparam logic [31:0] Seed = 32'h00481217;

	logic                                Clock;
	logic                                nReset;
	cpuControlPkg::instr_t               instr;
	logic [cpuControlPkg::FlagWidth-1:0] flags;
	logic                                nWait;
	logic                                nIrq;
	cpuControlPkg::busCtrl_t             bus;
	cpuControlPkg::pathCtrl_t            path;
	logic [cpuControlPkg::FlagWidth-1:0] statusReg;
	logic                                cFlag;

	int                                  irqLow;
	int                                  cycle;
	logic                                loadInstr;

	tbClock clockGen (
		.Clock  (Clock),
		.nReset (nReset)
	);

	cpuControl u_dut (
		.Clock     (Clock),
		.nReset    (nReset),
		.instr     (instr),
		.flags     (flags),
		.nWait     (nWait),
		.nIrq      (nIrq),
		.bus       (bus),
		.path      (path),
		.statusReg (statusReg),
		.cFlag     (cFlag)
	);

	`include "controlModel.svh"

	// Any defined opcode, INTCTRL only with a real subfunction
	function automatic cpuControlPkg::instr_t randomInstr();
		logic [31:0] r;
		logic [31:0] index;
		cpuControlPkg::instr_t value;
		r = $urandom;
		index = r % 32'd28;
		value.opcode = cpuControlPkg::opcode_t'(index[4:0]);
		if (value.opcode == cpuControlPkg::INTCTRL)
			value.cond.intCtrl = r[8] ? cpuControlPkg::IntOn : cpuControlPkg::IntOff;
		else
			value.cond.branch = cpuControlPkg::branchCond_t'(r[10:8]);
		return value;
	endfunction

	task automatic driveInputs();
		logic [31:0] r;
		r = $urandom;
		flags = r[3:0];
		// Memory not ready about one cycle in four
		nWait = r[5:4] != 2'b00;
		if (irqLow != 0) begin
			nIrq = 1'b0;
			irqLow = irqLow - 1;
		end else if (r[9:6] == 4'd0) begin
			nIrq = 1'b0;
			irqLow = 1 + int'(r[11:10]);
		end else begin
			nIrq = 1'b1;
		end
		if (loadInstr)
			instr = randomInstr();
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected 0x%0h actual 0x%0h at %0t ns",
				name, expected, actual, $time);
			$display("Test failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic compareOutputs();
		checkValue("bus.ale", 32'(expAle), 32'(bus.ale));
		checkValue("bus.nMe", 32'(expNMe), 32'(bus.nMe));
		checkValue("bus.nOe", 32'(expNOe), 32'(bus.nOe));
		checkValue("bus.nWe", 32'(expNWe), 32'(bus.nWe));
		checkValue("path.irWe", 32'(expIrWe), 32'(path.irWe));
		checkValue("path.regWe", 32'(expRegWe), 32'(path.regWe));
		checkValue("path.wdSel", 32'(expWdSel), 32'(path.wdSel));
		checkValue("path.pcWe", 32'(expPcWe), 32'(path.pcWe));
		checkValue("path.pcSel", 32'(expPcSel), 32'(path.pcSel));
		checkValue("path.lrEn", 32'(expLrEn), 32'(path.lrEn));
		checkValue("path.lrWe", 32'(expLrWe), 32'(path.lrWe));
		checkValue("statusReg", 32'(modelStatus), 32'(statusReg));
		checkValue("cFlag", 32'(modelStatus[cpuControlPkg::FlagC]), 32'(cFlag));
	endtask

	initial begin
		void'($urandom(Seed));
		instr = randomInstr();
		flags = '0;
		nWait = 1'b1;
		nIrq = 1'b1;
		irqLow = 0;
		loadInstr = 1'b0;
		instrDone = 0;
		entries = 0;
		resetModel();

		// Drive on the falling edge, check mid low phase, step the model on the rising edge
		for (cycle = 0; cycle < CycleLimit && instrDone < InstrCount; cycle++) begin
			@(negedge Clock);
			driveInputs();
			#5;
			if (nReset) begin
				predictOutputs(instr, nWait);
				compareOutputs();
				loadInstr = expIrWe;
			end else begin
				resetModel();
				loadInstr = 1'b0;
			end
			@(posedge Clock);
			if (nReset)
				advanceModel(instr, nWait, nIrq, flags);
		end

		if (instrDone < InstrCount) begin
			$display("Timeout after %0d cycles with only %0d instructions done",
				cycle, instrDone);
			$display("Test failed");
			$fatal(1, "Run did not finish in time");
		end else if (entries == 0) begin
			$display("No interrupt entry happened during the run");
			$display("Test failed");
			$fatal(1, "Interrupt path never exercised");
		end else begin
			$display("%0d instructions, %0d interrupt entries", instrDone, entries);
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* sim/tbClock.sv */
// Testbench clock and reset
module tbClock (
	output logic Clock,
	output logic nReset
);

	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// Reset over the first four periods, released on a falling edge
	initial begin
		nReset = 1'b0;
		repeat (4) @(posedge Clock);
		@(negedge Clock);
		nReset = 1'b1;
	end

endmodule
